// File: common/zx_config.svh
// port numbers decode the low address byte only
// reset pages follow the page_sel_u layout: bit 7 rom, bit 6 write-disable
`ifndef ZX_CONFIG_SVH
`define ZX_CONFIG_SVH

////////////////////
// i/o ports
////////////////////

// window page write, window in a[15:14]
`define ZX_PORT_PAGE_LO 8'hF7

// window page readback, window in a[9:8]
`define ZX_PORT_RDBK_LO 8'hBE

////////////////////
// power-up windows
////////////////////

// rom page 0 with writes blocked
`define ZX_RST_WIN0 8'hC0
// ram pages 5, 2 and 0
`define ZX_RST_WIN1 8'h05
`define ZX_RST_WIN2 8'h02
`define ZX_RST_WIN3 8'h00

`endif

// File: common/zx_bus_pkg.sv
// strobe bus operations, one operation per strobe cycle
// window numbers index the four 16 KB quarters of the z80 space
`default_nettype none

package zx_bus_pkg;

	////////////////////
	// bus operations
	////////////////////

	// encoding matches the bus_op pins of the top level
	typedef enum logic [1:0]
	{
		op_io_wr  = 2'd0,
		op_io_rd  = 2'd1,
		op_mem_rd = 2'd2,
		op_mem_wr = 2'd3
	} bus_op_t;

	////////////////////
	// windows
	////////////////////

	// 0 is 0000-3FFF, 3 is C000-FFFF
	typedef logic [1:0] win_idx_t;

endpackage

`default_nettype wire

// File: common/zx_map_pkg.sv
// page register word and physical address layout
// rom pages are 5 bits, ram pages 7 bits, both over 16 KB pages
`default_nettype none

package zx_map_pkg;

	////////////////////
	// page register
	////////////////////

	// rom view of a window register
	typedef struct packed
	{
		logic       is_rom;
		logic       wr_dis;
		logic       spare;
		logic [4:0] rom_page;
	} rom_sel_t;

	// ram view, no write protection here
	typedef struct packed
	{
		logic       is_rom;
		logic [6:0] ram_page;
	} ram_sel_t;

	// is_rom sits in bit 7 of both views and picks the one to use
	typedef union packed
	{
		rom_sel_t rom;
		ram_sel_t ram;
	} page_sel_u;

	////////////////////
	// physical address
	////////////////////

	// {page[6:0], offset[13:0]}, rom pages zero-extended
	typedef logic [20:0] phys_addr_t;

endpackage

`default_nettype wire

// File: common/zx_core_ifs.sv
// no back-pressure on either interface
// every strobe is taken in the cycle it is high
`default_nettype none
`timescale 1ns/1ps

// port decode to page registers to translator
interface page_if;
	logic                    wr_stb;
	logic                    fe_stb;
	zx_bus_pkg::win_idx_t    win;
	logic [7:0]              wdata;
	zx_bus_pkg::win_idx_t    rd_win;
	zx_map_pkg::page_sel_u   sel [4];
	logic [7:0]              rd_data;

	modport ctrl (output wr_stb, fe_stb, win, wdata, rd_win, input rd_data);
	modport regs (input wr_stb, fe_stb, win, wdata, rd_win, output sel, rd_data);
	modport xlat (input sel);
endinterface

// memory request from the strobe decoder
interface req_if;
	logic        valid;
	logic        we;
	logic [15:0] addr;
	logic [7:0]  wdata;

	modport ctrl (output valid, we, addr, wdata);
	modport xlat (input valid, we, addr, wdata);
endinterface

`default_nettype wire

// File: logic/bus_ctrl.sv
// all outputs are registered one cycle after bus_stb
// io_rdata is only meaningful while io_rvalid is high
`default_nettype none
`timescale 1ns/1ps

`include "zx_config.svh"

module bus_ctrl (
	input  wire                  fclk,
	input  wire                  arst_n,
	input  wire                  bus_stb,
	input  zx_bus_pkg::bus_op_t  bus_op,
	input  wire [15:0]           bus_addr,
	input  wire [7:0]            bus_wdata,
	page_if.ctrl                 pg,
	req_if.ctrl                  rq,
	output logic                 io_rvalid,
	output logic [7:0]           io_rdata
);

	logic is_io_wr;
	logic is_io_rd;
	logic is_mem;
	logic page_hit;
	logic fe_hit;
	logic rdbk_hit;
	logic rdbk_q;

	////////////////////
	// strobe decode
	////////////////////

	assign is_io_wr = bus_stb && (bus_op == zx_bus_pkg::op_io_wr);
	assign is_io_rd = bus_stb && (bus_op == zx_bus_pkg::op_io_rd);
	assign is_mem   = bus_stb && ((bus_op == zx_bus_pkg::op_mem_rd) ||
	                              (bus_op == zx_bus_pkg::op_mem_wr));

	// xxF7 has a0 set so it never hits the border port
	assign page_hit = (bus_addr[7:0] == `ZX_PORT_PAGE_LO);
	assign fe_hit   = !bus_addr[0];
	assign rdbk_hit = (bus_addr[7:0] == `ZX_PORT_RDBK_LO);

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pg.wr_stb <= 1'b0;
			pg.fe_stb <= 1'b0;
			rq.valid  <= 1'b0;
			io_rvalid <= 1'b0;
			rdbk_q    <= 1'b0;
		end
		else
		begin
			pg.wr_stb <= is_io_wr && page_hit;
			pg.fe_stb <= is_io_wr && fe_hit;
			rq.valid  <= is_mem;
			io_rvalid <= is_io_rd;
			rdbk_q    <= is_io_rd && rdbk_hit;
		end
	end

	// payload follows the strobe, qualified by the control bits above
	always_ff @(posedge fclk)
	begin
		if (bus_stb)
		begin
			pg.win    <= bus_addr[15:14];
			pg.wdata  <= bus_wdata;
			pg.rd_win <= bus_addr[9:8];
			rq.we     <= (bus_op == zx_bus_pkg::op_mem_wr);
			rq.addr   <= bus_addr;
			rq.wdata  <= bus_wdata;
		end
	end

	////////////////////
	// i/o read data
	////////////////////

	// unmapped ports float high on the real bus
	assign io_rdata = rdbk_q ? pg.rd_data : 8'hFF;

	a_op_known: assert property (@(posedge fclk) disable iff (!arst_n)
		bus_stb |-> !$isunknown(bus_op));

endmodule

`default_nettype wire

// File: paging/page_regs.sv
// window registers load at the end of the wr_stb cycle
// readback is combinational on rd_win
`default_nettype none
`timescale 1ns/1ps

`include "zx_config.svh"

module page_regs (
	input  wire         fclk,
	input  wire         arst_n,
	page_if.regs        pg,
	output logic [2:0]  border,
	output logic        beep
);

	localparam logic [7:0] rst_val [4] = '{
		`ZX_RST_WIN0,
		`ZX_RST_WIN1,
		`ZX_RST_WIN2,
		`ZX_RST_WIN3
	};

	zx_map_pkg::page_sel_u win_q [4];

	////////////////////
	// window registers
	////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < 4; i++)
			begin
				win_q[i] <= rst_val[i];
			end
		end
		else if (pg.wr_stb)
		begin
			win_q[pg.win] <= pg.wdata;
		end
	end

	assign pg.sel = win_q;

	// raw register byte, both views alike
	assign pg.rd_data = win_q[pg.rd_win];

	////////////////////
	// border and beeper
	////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			border <= 3'd0;
			beep   <= 1'b0;
		end
		else if (pg.fe_stb)
		begin
			border <= pg.wdata[2:0];
			// bit 3 is tape out, not kept
			beep   <= pg.wdata[4];
		end
	end

	// the decoder keeps xxF7 and the a0-clear ports apart
	a_one_port: assert property (@(posedge fclk) disable iff (!arst_n)
		!(pg.wr_stb && pg.fe_stb));

endmodule

`default_nettype wire

// File: paging/addr_xlat.sv
// request is registered here, so mem_req follows req valid by one cycle
// only rom windows can be write-disabled
`default_nettype none
`timescale 1ns/1ps

module addr_xlat (
	input  wire                     fclk,
	input  wire                     arst_n,
	page_if.xlat                    pg,
	req_if.xlat                     rq,
	output logic                    mem_req,
	output logic                    mem_we,
	output logic                    mem_rom,
	output zx_map_pkg::phys_addr_t  mem_addr,
	output logic [7:0]              mem_wdata,
	output logic                    wr_blocked
);

	zx_bus_pkg::win_idx_t   win;
	zx_map_pkg::page_sel_u  cur;
	logic                   is_rom;
	logic [6:0]             page;
	logic                   blocked;

	////////////////////
	// window decode
	////////////////////

	assign win = rq.addr[15:14];
	assign cur = pg.sel[win];

	// is_rom is shared, so either view gives it
	assign is_rom = cur.rom.is_rom;

	assign page = is_rom ? {2'b00, cur.rom.rom_page} : cur.ram.ram_page;

	assign blocked = rq.we && is_rom && cur.rom.wr_dis;

	////////////////////
	// request register
	////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			mem_req    <= 1'b0;
			wr_blocked <= 1'b0;
		end
		else
		begin
			mem_req    <= rq.valid && !blocked;
			wr_blocked <= rq.valid && blocked;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (rq.valid)
		begin
			mem_we    <= rq.we;
			mem_rom   <= is_rom;
			mem_addr  <= {page, rq.addr[13:0]};
			mem_wdata <= rq.wdata;
		end
	end

	// request payload and its window register must be settled
	a_req_known: assert property (@(posedge fclk) disable iff (!arst_n)
		rq.valid |-> !$isunknown({rq.we, rq.addr, is_rom, page}));

endmodule

`default_nettype wire

// File: logic/zx_mem_top.sv
// paging core behind a single-cycle strobe bus
// memory data is returned by external memory, not through this core
`default_nettype none
`timescale 1ns/1ps

module zx_mem_top (
	input  wire                     fclk,
	input  wire                     arst_n,
	input  wire                     bus_stb,
	input  zx_bus_pkg::bus_op_t     bus_op,
	input  wire [15:0]              bus_addr,
	input  wire [7:0]               bus_wdata,
	output logic                    io_rvalid,
	output logic [7:0]              io_rdata,
	output logic                    mem_req,
	output logic                    mem_we,
	output logic                    mem_rom,
	output zx_map_pkg::phys_addr_t  mem_addr,
	output logic [7:0]              mem_wdata,
	output logic                    wr_blocked,
	output logic [2:0]              border,
	output logic                    beep
);

	page_if pg ();
	req_if  rq ();

	bus_ctrl u_ctrl (
		.fclk      (fclk),
		.arst_n    (arst_n),
		.bus_stb   (bus_stb),
		.bus_op    (bus_op),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.pg        (pg.ctrl),
		.rq        (rq.ctrl),
		.io_rvalid (io_rvalid),
		.io_rdata  (io_rdata)
	);

	page_regs u_regs (
		.fclk   (fclk),
		.arst_n (arst_n),
		.pg     (pg.regs),
		.border (border),
		.beep   (beep)
	);

	addr_xlat u_xlat (
		.fclk       (fclk),
		.arst_n     (arst_n),
		.pg         (pg.xlat),
		.rq         (rq.xlat),
		.mem_req    (mem_req),
		.mem_we     (mem_we),
		.mem_rom    (mem_rom),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.wr_blocked (wr_blocked)
	);

endmodule

`default_nettype wire

// File: tests/tb_model.svh
// reference model, included inside the testbench module
// memory responses are packed as {blocked, we, rom, phys addr, wdata}
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [7:0] m_win [4];
logic [2:0] m_border;
logic       m_beep;

// rom 0 write-disabled, then ram 5, 2 and 0
task automatic model_reset();
	m_win[0] = {1'b1, 1'b1, 1'b0, 5'd0};
	m_win[1] = {1'b0, 7'd5};
	m_win[2] = {1'b0, 7'd2};
	m_win[3] = {1'b0, 7'd0};
	m_border = 3'd0;
	m_beep   = 1'b0;
endtask

// xxF7 loads a window, any even port is the border port
task automatic model_io_write(input logic [15:0] addr, input logic [7:0] wdata);
	if (addr[7:0] == 8'hF7)
		m_win[addr[15:14]] = wdata;
	else if (!addr[0])
	begin
		m_border = wdata[2:0];
		m_beep   = wdata[4];
	end
endtask

function automatic logic [7:0] model_io_read(input logic [15:0] addr);
	if (addr[7:0] == 8'hBE)
		return m_win[addr[9:8]];
	return 8'hFF;
endfunction

function automatic logic [31:0] model_mem(input logic we, input logic [15:0] addr,
		input logic [7:0] wdata);
	logic [7:0] w;
	logic [6:0] page;
	w = m_win[addr[15:14]];
	// bit 7 rom, bit 6 write-disable in the rom view
	page = w[7] ? {2'b00, w[4:0]} : w[6:0];
	return {we && w[7] && w[6], we, w[7], page, addr[13:0], wdata};
endfunction

`endif

// File: tests/tb_zx_mem.sv
// random and directed bus strobes against the model in tb_model.svh
// each response is checked on the exact cycle the bus timing gives it
`timescale 1ns/1ps
`default_nettype none

module tb_zx_mem;

	logic                    fclk;
	logic                    arst_n;
	logic                    bus_stb;
	zx_bus_pkg::bus_op_t     bus_op;
	logic [15:0]             bus_addr;
	logic [7:0]              bus_wdata;
	logic                    io_rvalid;
	logic [7:0]              io_rdata;
	logic                    mem_req;
	logic                    mem_we;
	logic                    mem_rom;
	zx_map_pkg::phys_addr_t  mem_addr;
	logic [7:0]              mem_wdata;
	logic                    wr_blocked;
	logic [2:0]              border;
	logic                    beep;

	logic [31:0] rng;
	int          cyc;
	int          value_errs;
	int          other_errs;
	int          io_due [$];
	logic [7:0]  io_exp [$];
	int          mem_due [$];
	logic [31:0] mem_exp [$];
	logic [2:0]  border_exp;
	logic        beep_exp;

	`include "tb_model.svh"

	zx_mem_top dut0 (.*);

	initial
	begin
		fclk = 1'b0;
		forever
			#5 fclk = ~fclk;
	end

	////////////////////
	// random numbers
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// ports F7, BE and FE come up more often
	function automatic logic [15:0] pick_addr(input logic [31:0] r);
		case (r[2:0])
			3'd0, 3'd1: return {r[31:24], 8'hF7};
			3'd2:       return {r[31:24], 8'hBE};
			3'd3:       return {r[31:24], 8'hFE};
			default:    return r[31:16];
		endcase
	endfunction

	////////////////////
	// checks
	////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("CHECK FAILED %s got %h expected %h at cycle %0d", name, got, exp, cyc);
		value_errs++;
	endtask

	task automatic check_outputs();
		logic [31:0] e;
		if (io_due.size() > 0 && io_due[0] == cyc)
		begin
			if (io_rvalid !== 1'b1)
				report_mismatch("io_rvalid", 32'(io_rvalid), 32'd1);
			else if (io_rdata !== io_exp[0])
				report_mismatch("io_rdata", 32'(io_rdata), 32'(io_exp[0]));
			io_due.delete(0);
			io_exp.delete(0);
		end
		else if (io_rvalid !== 1'b0)
			report_mismatch("io_rvalid", 32'(io_rvalid), 32'd0);
		if (mem_due.size() > 0 && mem_due[0] == cyc)
		begin
			e = mem_exp[0];
			mem_due.delete(0);
			mem_exp.delete(0);
			if (mem_req !== !e[31])
				report_mismatch("mem_req", 32'(mem_req), 32'(!e[31]));
			if (wr_blocked !== e[31])
				report_mismatch("wr_blocked", 32'(wr_blocked), 32'(e[31]));
			if (!e[31] && mem_we !== e[30])
				report_mismatch("mem_we", 32'(mem_we), 32'(e[30]));
			if (!e[31] && mem_rom !== e[29])
				report_mismatch("mem_rom", 32'(mem_rom), 32'(e[29]));
			if (!e[31] && mem_addr !== e[28:8])
				report_mismatch("mem_addr", 32'(mem_addr), 32'(e[28:8]));
			if (!e[31] && e[30] && mem_wdata !== e[7:0])
				report_mismatch("mem_wdata", 32'(mem_wdata), 32'(e[7:0]));
		end
		else
		begin
			if (mem_req !== 1'b0)
				report_mismatch("mem_req", 32'(mem_req), 32'd0);
			if (wr_blocked !== 1'b0)
				report_mismatch("wr_blocked", 32'(wr_blocked), 32'd0);
		end
		// border lags its write strobe by two edges
		if (border !== border_exp)
			report_mismatch("border", 32'(border), 32'(border_exp));
		if (beep !== beep_exp)
			report_mismatch("beep", 32'(beep), 32'(beep_exp));
		border_exp = m_border;
		beep_exp   = m_beep;
	endtask

	////////////////////
	// bus driver
	////////////////////

	task automatic drive_op(input logic stb, input zx_bus_pkg::bus_op_t op,
			input logic [15:0] addr, input logic [7:0] wdata);
		@(negedge fclk);
		cyc++;
		check_outputs();
		bus_stb   = stb;
		bus_op    = op;
		bus_addr  = addr;
		bus_wdata = wdata;
		if (stb)
		begin
			case (op)
				zx_bus_pkg::op_io_wr:
					model_io_write(addr, wdata);
				zx_bus_pkg::op_io_rd:
				begin
					io_due.push_back(cyc + 1);
					io_exp.push_back(model_io_read(addr));
				end
				default:
				begin
					mem_due.push_back(cyc + 2);
					mem_exp.push_back(model_mem(op == zx_bus_pkg::op_mem_wr, addr, wdata));
				end
			endcase
		end
	endtask

	task automatic idle_cycle();
		drive_op(1'b0, zx_bus_pkg::op_io_rd, 16'h0000, 8'h00);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] wdata);
		drive_op(1'b1, zx_bus_pkg::op_io_wr, addr, wdata);
	endtask

	task automatic io_read(input logic [15:0] addr);
		drive_op(1'b1, zx_bus_pkg::op_io_rd, addr, 8'h00);
	endtask

	task automatic mem_access(input logic we, input logic [15:0] addr, input logic [7:0] wdata);
		drive_op(1'b1, we ? zx_bus_pkg::op_mem_wr : zx_bus_pkg::op_mem_rd, addr, wdata);
	endtask

	task automatic drain_responses();
		int n;
		n = 0;
		while ((io_due.size() > 0 || mem_due.size() > 0) && n < 10)
		begin
			idle_cycle();
			n++;
		end
		if (io_due.size() > 0 || mem_due.size() > 0)
		begin
			$display("timeout: expected bus responses never arrived");
			other_errs++;
			io_due.delete();
			io_exp.delete();
			mem_due.delete();
			mem_exp.delete();
		end
		idle_cycle();
		idle_cycle();
	endtask

	initial
	begin
		logic [31:0] r;
		logic [31:0] a;
		logic [1:0]  w;
		rng        = 32'd50;
		cyc        = 0;
		value_errs = 0;
		other_errs = 0;
		arst_n     = 1'b0;
		bus_stb    = 1'b0;
		bus_op     = zx_bus_pkg::op_io_wr;
		bus_addr   = 16'h0000;
		bus_wdata  = 8'h00;
		model_reset();
		border_exp = 3'd0;
		beep_exp   = 1'b0;
		repeat (5)
			@(negedge fclk);
		arst_n = 1'b1;

		// readback of the power-up windows
		for (int i = 0; i < 4; i++)
			io_read({6'd0, 2'(i), 8'hBE});
		drain_responses();

		// page write then readback of the same window
		for (int i = 0; i < 8; i++)
		begin
			r = next_rand();
			io_write({r[1:0], 6'd0, 8'hF7}, r[15:8]);
			io_read({6'd0, r[1:0], 8'hBE});
		end
		drain_responses();

		// every window in both views, new page used from the next strobe
		for (int i = 0; i < 4; i++)
		begin
			r = next_rand();
			w = 2'(i);
			mem_access(1'b0, {w, r[13:0]}, 8'h00);
			io_write({w, 6'd0, 8'hF7}, {1'b0, r[22:16]});
			mem_access(1'b0, {w, r[13:0]}, 8'h00);
			io_write({w, 6'd0, 8'hF7}, {3'b100, r[28:24]});
			mem_access(1'b1, {w, r[13:0]}, r[7:0]);
		end
		drain_responses();

		// window 1 protected rom, window 2 ram
		io_write(16'h40F7, 8'hC3);
		io_write(16'h80F7, 8'h11);
		mem_access(1'b1, 16'h4123, 8'h5A);
		mem_access(1'b1, 16'h8123, 8'hA5);
		io_write(16'h40F7, 8'h83);
		mem_access(1'b1, 16'h4124, 8'h3C);
		drain_responses();

		// unmapped reads, then border and beeper writes
		io_read(16'h001F);
		io_read(16'h00FE);
		io_read(16'h12F7);
		r = next_rand();
		io_write(16'h00FE, r[7:0]);
		io_write(16'h347C, r[15:8]);
		drain_responses();

		// back-to-back random strobes
		for (int i = 0; i < 2000; i++)
		begin
			r = next_rand();
			a = next_rand();
			drive_op(1'b1, zx_bus_pkg::bus_op_t'(r[1:0]), pick_addr(a), r[15:8]);
		end
		drain_responses();

		$display("errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
+incdir+tests
common/zx_bus_pkg.sv
common/zx_map_pkg.sv
common/zx_core_ifs.sv
logic/bus_ctrl.sv
paging/page_regs.sv
paging/addr_xlat.sv
logic/zx_mem_top.sv
tests/tb_zx_mem.sv

// File: run_sim.sh
#!/bin/sh
# builds tb_zx_mem with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --timing --assert -f verilog.f --top-module tb_zx_mem -o tb_zx_mem
then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/tb_zx_mem > sim.log 2>&1
then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi

cat sim.log

if grep -qx "all tests passed" sim.log
then
	exit 0
fi
echo "simulation reported failures"
exit 1
